// ==== rtl/periph_settings.svh ====
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// Bus and vector widths
`define PERIPH_ADDR_WIDTH 16
`define PERIPH_DATA_WIDTH 32
`define PERIPH_NUM_IRQ    32
`define PERIPH_GPIO_WIDTH 32

// Slave slots, taken from paddr[15:12]
`define PERIPH_SLOT_GPIO  4'd0
`define PERIPH_SLOT_TIMER 4'd1
`define PERIPH_SLOT_EVENT 4'd2
`define PERIPH_SLOT_SOC   4'd3

// Register word offsets, taken from paddr[5:2]
`define GPIO_DIR      4'd0
`define GPIO_OUT      4'd1
`define GPIO_IN       4'd2
`define GPIO_INT_EN   4'd3
`define TIMER_CTRL    4'd0
`define TIMER_VALUE   4'd1
`define TIMER_CMP     4'd2
`define EVT_ENABLE    4'd0
`define EVT_PENDING   4'd1
`define SOC_BOOT_ADDR 4'd0
`define SOC_PAD_MUX   4'd1
`define SOC_CLK_GATE  4'd2

`define PERIPH_BOOT_ADDR_RESET 32'h0000_8000

// Interrupt source bits and clock-gate bits
`define PERIPH_IRQ_GPIO   0
`define PERIPH_IRQ_TIMER  1
`define PERIPH_GATE_GPIO  0
`define PERIPH_GATE_TIMER 1

`endif

// ==== rtl/periph_pkg.sv ====
`include "periph_settings.svh"

package periph_pkg;

  // APB address as seen at the subsystem port
  typedef logic [`PERIPH_ADDR_WIDTH-1:0] apb_addr_t;

  // One APB data word, also the width of every register
  typedef logic [`PERIPH_DATA_WIDTH-1:0] apb_data_t;

  // Word index of a register inside one slave
  typedef logic [3:0] reg_offset_t;

  // Slave slot number
  typedef logic [3:0] periph_slot_t;

  // Interrupt vector, one bit per source
  typedef logic [`PERIPH_NUM_IRQ-1:0] irq_vec_t;

  // One bit per GPIO pin
  typedef logic [`PERIPH_GPIO_WIDTH-1:0] gpio_vec_t;

  // Clock enables of the gated slaves
  //   bit 0 GPIO
  //   bit 1 timer
  typedef logic [1:0] clk_gate_t;

endpackage

// ==== rtl/periph_apb_decoder.sv ====
`timescale 1ns/1ns

`include "periph_settings.svh"

module periph_apb_decoder (
  input  logic                    clk_int,
  input  logic                    rst_n,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  periph_pkg::apb_addr_t   paddr_i,
  input  periph_pkg::apb_data_t   rdata_gpio_i,
  input  periph_pkg::apb_data_t   rdata_timer_i,
  input  periph_pkg::apb_data_t   rdata_evt_i,
  input  periph_pkg::apb_data_t   rdata_soc_i,
  output logic                    sel_gpio_o,
  output logic                    sel_timer_o,
  output logic                    sel_evt_o,
  output logic                    sel_soc_o,
  output periph_pkg::reg_offset_t offset_o,
  output periph_pkg::apb_data_t   prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o
);

  periph_pkg::periph_slot_t slot;
  logic                     mapped;

  // Upper nibble picks the slave, word index inside it from bits 5:2
  assign slot     = paddr_i[15:12];
  assign offset_o = paddr_i[5:2];

  always_comb begin
    sel_gpio_o  = 1'b0;
    sel_timer_o = 1'b0;
    sel_evt_o   = 1'b0;
    sel_soc_o   = 1'b0;
    prdata_o    = '0;
    mapped      = 1'b1;
    case (slot)
      `PERIPH_SLOT_GPIO: begin
        sel_gpio_o = psel_i;
        prdata_o   = rdata_gpio_i;
      end
      `PERIPH_SLOT_TIMER: begin
        sel_timer_o = psel_i;
        prdata_o    = rdata_timer_i;
      end
      `PERIPH_SLOT_EVENT: begin
        sel_evt_o = psel_i;
        prdata_o  = rdata_evt_i;
      end
      `PERIPH_SLOT_SOC: begin
        sel_soc_o = psel_i;
        prdata_o  = rdata_soc_i;
      end
      default: mapped = 1'b0;
    endcase
  end

  // Zero wait states on every slave
  assign pready_o  = 1'b1;
  assign pslverr_o = psel_i & penable_i & ~mapped;

  a_one_sel: assert property (@(posedge clk_int) disable iff (!rst_n)
    $onehot0({sel_gpio_o, sel_timer_o, sel_evt_o, sel_soc_o}))
    else $error("More than one APB slave selected");

  // Access phase must follow a setup phase of the same transfer
  a_setup_first: assert property (@(posedge clk_int) disable iff (!rst_n)
    $rose(penable_i) |-> psel_i && $past(psel_i))
    else $error("penable rose without a setup cycle");

endmodule

// ==== rtl/periph_gpio.sv ====
`timescale 1ns/1ns

`include "periph_settings.svh"

module periph_gpio (
  input  logic                    clk_int,
  input  logic                    rst_n,
  input  logic                    clk_en_i,
  input  logic                    sel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  periph_pkg::reg_offset_t offset_i,
  input  periph_pkg::apb_data_t   pwdata_i,
  input  periph_pkg::gpio_vec_t   gpio_in_i,
  output periph_pkg::apb_data_t   rdata_o,
  output periph_pkg::gpio_vec_t   gpio_out_o,
  output periph_pkg::gpio_vec_t   gpio_dir_o,
  output logic                    irq_o
);

  periph_pkg::gpio_vec_t dir_q;
  periph_pkg::gpio_vec_t out_q;
  periph_pkg::gpio_vec_t int_en_q;
  periph_pkg::gpio_vec_t sync1_q;
  periph_pkg::gpio_vec_t sync2_q;
  periph_pkg::gpio_vec_t in_q;
  periph_pkg::gpio_vec_t rise;
  logic                  irq_q;
  logic                  write_en;

  assign write_en = sel_i & penable_i & pwrite_i;

  // Enabled pins going from low to high after the synchroniser
  assign rise = sync2_q & ~in_q & int_en_q;

  always_ff @(posedge clk_int) begin
    if (!rst_n) begin
      dir_q    <= '0;
      out_q    <= '0;
      int_en_q <= '0;
      sync1_q  <= '0;
      sync2_q  <= '0;
      in_q     <= '0;
      irq_q    <= 1'b0;
    end else if (clk_en_i) begin
      if (write_en && offset_i == `GPIO_DIR)    dir_q    <= pwdata_i;
      if (write_en && offset_i == `GPIO_OUT)    out_q    <= pwdata_i;
      if (write_en && offset_i == `GPIO_INT_EN) int_en_q <= pwdata_i;
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      in_q    <= sync2_q;
      irq_q   <= |rise;
    end
  end

  always_comb begin
    case (offset_i)
      `GPIO_DIR:    rdata_o = dir_q;
      `GPIO_OUT:    rdata_o = out_q;
      `GPIO_IN:     rdata_o = in_q;
      `GPIO_INT_EN: rdata_o = int_en_q;
      default:      rdata_o = '0;
    endcase
  end

  assign gpio_out_o = out_q;
  assign gpio_dir_o = dir_q;
  assign irq_o      = irq_q;

endmodule

// ==== rtl/periph_timer.sv ====
`timescale 1ns/1ns

`include "periph_settings.svh"

module periph_timer (
  input  logic                    clk_int,
  input  logic                    rst_n,
  input  logic                    clk_en_i,
  input  logic                    sel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  periph_pkg::reg_offset_t offset_i,
  input  periph_pkg::apb_data_t   pwdata_i,
  output periph_pkg::apb_data_t   rdata_o,
  output logic                    irq_o
);

  logic                  ctrl_en_q;
  periph_pkg::apb_data_t value_q;
  periph_pkg::apb_data_t cmp_q;
  logic                  write_en;
  logic                  value_we;
  logic                  running;
  logic                  match;

  assign write_en = sel_i & penable_i & pwrite_i;
  assign value_we = write_en && (offset_i == `TIMER_VALUE);

  // Counting needs both the gate bit and CTRL bit 0
  assign running = clk_en_i & ctrl_en_q;
  assign match   = (value_q == cmp_q);

  // Pulse lines up with the cycle that holds the matching value
  assign irq_o = running & match;

  ////////////////////////////////////////
  // Registers and counter
  ////////////////////////////////////////

  always_ff @(posedge clk_int) begin
    if (!rst_n) begin
      ctrl_en_q <= 1'b0;
      value_q   <= '0;
      cmp_q     <= '0;
    end else if (clk_en_i) begin
      if (write_en && offset_i == `TIMER_CTRL) ctrl_en_q <= pwdata_i[0];
      if (write_en && offset_i == `TIMER_CMP)  cmp_q     <= pwdata_i;
      if (value_we) begin
        value_q <= pwdata_i;
      end else if (ctrl_en_q) begin
        // Wrap to zero after the compare value
        if (match) begin
          value_q <= '0;
        end else begin
          value_q <= value_q + 32'd1;
        end
      end
    end
  end

  always_comb begin
    case (offset_i)
      `TIMER_CTRL:  rdata_o = {{(`PERIPH_DATA_WIDTH-1){1'b0}}, ctrl_en_q};
      `TIMER_VALUE: rdata_o = value_q;
      `TIMER_CMP:   rdata_o = cmp_q;
      default:      rdata_o = '0;
    endcase
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_irq_enabled: assert property (@(posedge clk_int) disable iff (!rst_n)
    irq_o |-> ctrl_en_q && clk_en_i)
    else $error("Timer interrupt while the timer is stopped");

endmodule

// ==== rtl/periph_event_unit.sv ====
`timescale 1ns/1ns

`include "periph_settings.svh"

module periph_event_unit (
  input  logic                    clk_int,
  input  logic                    rst_n,
  input  logic                    sel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  periph_pkg::reg_offset_t offset_i,
  input  periph_pkg::apb_data_t   pwdata_i,
  input  periph_pkg::irq_vec_t    irq_src_i,
  output periph_pkg::apb_data_t   rdata_o,
  output periph_pkg::irq_vec_t    irq_o
);

  periph_pkg::irq_vec_t enable_q;
  periph_pkg::irq_vec_t pending_q;
  periph_pkg::irq_vec_t irq_q;
  periph_pkg::irq_vec_t clear;
  logic                 write_en;

  assign write_en = sel_i & penable_i & pwrite_i;

  // Write one to clear a pending bit
  always_comb begin
    if (write_en && offset_i == `EVT_PENDING) begin
      clear = pwdata_i;
    end else begin
      clear = '0;
    end
  end

  ////////////////////////////////////////
  // Pending and mask
  ////////////////////////////////////////

  always_ff @(posedge clk_int) begin
    if (!rst_n) begin
      enable_q  <= '0;
      pending_q <= '0;
      irq_q     <= '0;
    end else begin
      if (write_en && offset_i == `EVT_ENABLE) begin
        enable_q <= pwdata_i;
      end
      // A new pulse beats a clear in the same cycle
      pending_q <= (pending_q & ~clear) | irq_src_i;
      irq_q     <= pending_q & enable_q;
    end
  end

  always_comb begin
    case (offset_i)
      `EVT_ENABLE:  rdata_o = enable_q;
      `EVT_PENDING: rdata_o = pending_q;
      default:      rdata_o = '0;
    endcase
  end

  assign irq_o = irq_q;

  // irq_o lags the mask by one cycle, so compare against the previous mask
  a_irq_masked: assert property (@(posedge clk_int) disable iff (!rst_n)
    (irq_o & ~$past(enable_q)) == '0)
    else $error("Interrupt raised for a masked source");

endmodule

// ==== rtl/periph_soc_ctrl.sv ====
`timescale 1ns/1ns

`include "periph_settings.svh"

module periph_soc_ctrl (
  input  logic                    clk_int,
  input  logic                    rst_n,
  input  logic                    sel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  periph_pkg::reg_offset_t offset_i,
  input  periph_pkg::apb_data_t   pwdata_i,
  output periph_pkg::apb_data_t   rdata_o,
  output periph_pkg::apb_data_t   boot_addr_o,
  output periph_pkg::apb_data_t   pad_mux_o,
  output periph_pkg::clk_gate_t   clk_gate_o
);

  periph_pkg::apb_data_t boot_addr_q;
  periph_pkg::apb_data_t pad_mux_q;
  periph_pkg::clk_gate_t clk_gate_q;
  logic                  write_en;

  assign write_en = sel_i & penable_i & pwrite_i;

  // This block always runs on the ungated clock
  always_ff @(posedge clk_int) begin
    if (!rst_n) begin
      boot_addr_q <= `PERIPH_BOOT_ADDR_RESET;
      pad_mux_q   <= '0;
      clk_gate_q  <= '1;
    end else if (write_en) begin
      if (offset_i == `SOC_BOOT_ADDR) boot_addr_q <= pwdata_i;
      if (offset_i == `SOC_PAD_MUX)   pad_mux_q   <= pwdata_i;
      if (offset_i == `SOC_CLK_GATE)  clk_gate_q  <= pwdata_i[1:0];
    end
  end

  always_comb begin
    case (offset_i)
      `SOC_BOOT_ADDR: rdata_o = boot_addr_q;
      `SOC_PAD_MUX:   rdata_o = pad_mux_q;
      `SOC_CLK_GATE:  rdata_o = {{(`PERIPH_DATA_WIDTH-2){1'b0}}, clk_gate_q};
      default:        rdata_o = '0;
    endcase
  end

  assign boot_addr_o = boot_addr_q;
  assign pad_mux_o   = pad_mux_q;
  assign clk_gate_o  = clk_gate_q;

endmodule

// ==== rtl/periph_subsystem.sv ====
`timescale 1ns/1ns

`include "periph_settings.svh"

module periph_subsystem (
  input  logic                  clk_int,
  input  logic                  rst_n,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::apb_addr_t paddr_i,
  input  periph_pkg::apb_data_t pwdata_i,
  input  periph_pkg::gpio_vec_t gpio_in_i,
  output periph_pkg::apb_data_t prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output periph_pkg::gpio_vec_t gpio_out_o,
  output periph_pkg::gpio_vec_t gpio_dir_o,
  output periph_pkg::irq_vec_t  irq_o,
  output periph_pkg::apb_data_t pad_mux_o,
  output periph_pkg::apb_data_t boot_addr_o
);

  logic                    sel_gpio;
  logic                    sel_timer;
  logic                    sel_evt;
  logic                    sel_soc;
  periph_pkg::reg_offset_t offset;
  periph_pkg::apb_data_t   rdata_gpio;
  periph_pkg::apb_data_t   rdata_timer;
  periph_pkg::apb_data_t   rdata_evt;
  periph_pkg::apb_data_t   rdata_soc;
  logic                    gpio_irq;
  logic                    timer_irq;
  periph_pkg::irq_vec_t    irq_src;
  periph_pkg::clk_gate_t   clk_gate;

  ////////////////////////////////////////
  // APB decode
  ////////////////////////////////////////

  periph_apb_decoder decoder_i (
    .clk_int       ( clk_int     ),
    .rst_n         ( rst_n       ),
    .psel_i        ( psel_i      ),
    .penable_i     ( penable_i   ),
    .paddr_i       ( paddr_i     ),
    .rdata_gpio_i  ( rdata_gpio  ),
    .rdata_timer_i ( rdata_timer ),
    .rdata_evt_i   ( rdata_evt   ),
    .rdata_soc_i   ( rdata_soc   ),
    .sel_gpio_o    ( sel_gpio    ),
    .sel_timer_o   ( sel_timer   ),
    .sel_evt_o     ( sel_evt     ),
    .sel_soc_o     ( sel_soc     ),
    .offset_o      ( offset      ),
    .prdata_o      ( prdata_o    ),
    .pready_o      ( pready_o    ),
    .pslverr_o     ( pslverr_o   )
  );

  ////////////////////////////////////////
  // Gated slaves
  ////////////////////////////////////////

  periph_gpio gpio_i (
    .clk_int    ( clk_int                      ),
    .rst_n      ( rst_n                        ),
    .clk_en_i   ( clk_gate[`PERIPH_GATE_GPIO]  ),
    .sel_i      ( sel_gpio                     ),
    .penable_i  ( penable_i                    ),
    .pwrite_i   ( pwrite_i                     ),
    .offset_i   ( offset                       ),
    .pwdata_i   ( pwdata_i                     ),
    .gpio_in_i  ( gpio_in_i                    ),
    .rdata_o    ( rdata_gpio                   ),
    .gpio_out_o ( gpio_out_o                   ),
    .gpio_dir_o ( gpio_dir_o                   ),
    .irq_o      ( gpio_irq                     )
  );

  periph_timer timer_i (
    .clk_int   ( clk_int                      ),
    .rst_n     ( rst_n                        ),
    .clk_en_i  ( clk_gate[`PERIPH_GATE_TIMER] ),
    .sel_i     ( sel_timer                    ),
    .penable_i ( penable_i                    ),
    .pwrite_i  ( pwrite_i                     ),
    .offset_i  ( offset                       ),
    .pwdata_i  ( pwdata_i                     ),
    .rdata_o   ( rdata_timer                  ),
    .irq_o     ( timer_irq                    )
  );

  // Unused interrupt lines stay low
  always_comb begin
    irq_src                    = '0;
    irq_src[`PERIPH_IRQ_GPIO]  = gpio_irq;
    irq_src[`PERIPH_IRQ_TIMER] = timer_irq;
  end

  ////////////////////////////////////////
  // Always-clocked slaves
  ////////////////////////////////////////

  periph_event_unit event_unit_i (
    .clk_int   ( clk_int   ),
    .rst_n     ( rst_n     ),
    .sel_i     ( sel_evt   ),
    .penable_i ( penable_i ),
    .pwrite_i  ( pwrite_i  ),
    .offset_i  ( offset    ),
    .pwdata_i  ( pwdata_i  ),
    .irq_src_i ( irq_src   ),
    .rdata_o   ( rdata_evt ),
    .irq_o     ( irq_o     )
  );

  periph_soc_ctrl soc_ctrl_i (
    .clk_int     ( clk_int     ),
    .rst_n       ( rst_n       ),
    .sel_i       ( sel_soc     ),
    .penable_i   ( penable_i   ),
    .pwrite_i    ( pwrite_i    ),
    .offset_i    ( offset      ),
    .pwdata_i    ( pwdata_i    ),
    .rdata_o     ( rdata_soc   ),
    .boot_addr_o ( boot_addr_o ),
    .pad_mux_o   ( pad_mux_o   ),
    .clk_gate_o  ( clk_gate    )
  );

endmodule

// ==== verification/periph_checker.sv ====
`timescale 1ns/1ns

module periph_checker (
  input  logic                  clk_int,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  periph_pkg::apb_data_t prdata_i,
  input  logic                  pready_i,
  input  logic                  pslverr_i,
  input  periph_pkg::apb_data_t boot_addr_i,
  input  periph_pkg::apb_data_t pad_mux_i,
  input  periph_pkg::gpio_vec_t gpio_out_i,
  input  periph_pkg::gpio_vec_t gpio_dir_i,
  input  periph_pkg::irq_vec_t  irq_i,
  input  logic                  read_chk_i,
  input  logic                  port_chk_i,
  input  logic [2:0]            port_sel_i,
  input  periph_pkg::apb_data_t exp_data_i,
  input  logic                  exp_err_i,
  output int                    error_count_o
);

  int                    errors;
  periph_pkg::apb_data_t port_val;
  string                 port_label;

  // Select the port under test by the testbench port code
  always_comb begin
    case (port_sel_i)
      3'd0:    port_val = boot_addr_i;
      3'd1:    port_val = pad_mux_i;
      3'd2:    port_val = gpio_out_i;
      3'd3:    port_val = gpio_dir_i;
      default: port_val = irq_i;
    endcase
  end

  always_comb begin
    case (port_sel_i)
      3'd0:    port_label = "boot_addr_o";
      3'd1:    port_label = "pad_mux_o";
      3'd2:    port_label = "gpio_out_o";
      3'd3:    port_label = "gpio_dir_o";
      default: port_label = "irq_o";
    endcase
  end

  initial errors = 0;

  ////////////////////////////////////////
  // Sampling at the edge that ends a cycle
  ////////////////////////////////////////

  always @(posedge clk_int) begin
    if (psel_i && penable_i && !pready_i) begin
      $display("Fail at %0t: pready_o is low in an APB access cycle", $time);
      errors = errors + 1;
    end
    if (read_chk_i) begin
      if (prdata_i !== exp_data_i) begin
        $display("Fail at %0t: prdata_o is %h, expected %h", $time, prdata_i, exp_data_i);
        errors = errors + 1;
      end
      if (pslverr_i !== exp_err_i) begin
        $display("Fail at %0t: pslverr_o is %b, expected %b", $time, pslverr_i, exp_err_i);
        errors = errors + 1;
      end
    end
    if (port_chk_i && port_val !== exp_data_i) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, port_label, port_val, exp_data_i);
      errors = errors + 1;
    end
  end

  assign error_count_o = errors;

endmodule

// ==== verification/periph_tb.sv ====
`timescale 1ns/1ns

module periph_tb;

  localparam string stim_file = "verification/periph_stim.txt";

  logic                  clk_int;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  periph_pkg::apb_addr_t paddr;
  periph_pkg::apb_data_t pwdata;
  periph_pkg::gpio_vec_t gpio_in;
  periph_pkg::apb_data_t prdata;
  logic                  pready;
  logic                  pslverr;
  periph_pkg::gpio_vec_t gpio_out;
  periph_pkg::gpio_vec_t gpio_dir;
  periph_pkg::irq_vec_t  irq;
  periph_pkg::apb_data_t pad_mux;
  periph_pkg::apb_data_t boot_addr;

  // Requests to the checker
  logic                  read_chk;
  logic                  port_chk;
  logic [2:0]            port_sel;
  periph_pkg::apb_data_t exp_data;
  logic                  exp_err;
  int                    error_count;

  int                    cycle_limit;
  int                    cycle_count;
  int                    stim_errors;
  int                    tests_passed;
  int                    tests_failed;
  int                    errors_at_start;
  int                    test_num;
  logic [8*32-1:0]       test_name;

  periph_subsystem dut_i (
    .clk_int     ( clk_int   ),
    .rst_n       ( rst_n     ),
    .psel_i      ( psel      ),
    .penable_i   ( penable   ),
    .pwrite_i    ( pwrite    ),
    .paddr_i     ( paddr     ),
    .pwdata_i    ( pwdata    ),
    .gpio_in_i   ( gpio_in   ),
    .prdata_o    ( prdata    ),
    .pready_o    ( pready    ),
    .pslverr_o   ( pslverr   ),
    .gpio_out_o  ( gpio_out  ),
    .gpio_dir_o  ( gpio_dir  ),
    .irq_o       ( irq       ),
    .pad_mux_o   ( pad_mux   ),
    .boot_addr_o ( boot_addr )
  );

  periph_checker checker_i (
    .clk_int       ( clk_int     ),
    .psel_i        ( psel        ),
    .penable_i     ( penable     ),
    .prdata_i      ( prdata      ),
    .pready_i      ( pready      ),
    .pslverr_i     ( pslverr     ),
    .boot_addr_i   ( boot_addr   ),
    .pad_mux_i     ( pad_mux     ),
    .gpio_out_i    ( gpio_out    ),
    .gpio_dir_i    ( gpio_dir    ),
    .irq_i         ( irq         ),
    .read_chk_i    ( read_chk    ),
    .port_chk_i    ( port_chk    ),
    .port_sel_i    ( port_sel    ),
    .exp_data_i    ( exp_data    ),
    .exp_err_i     ( exp_err     ),
    .error_count_o ( error_count )
  );

  initial begin
    clk_int = 1'b0;
    forever #4 clk_int = ~clk_int;
  end

  ////////////////////////////////////////
  // File helpers
  ////////////////////////////////////////

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    // Stop on newline or end of file
    while (c != 10 && c >= 0) begin
      c = $fgetc(fd);
    end
  endtask

  // Counts commands and wait cycles to size the timeout
  task automatic scan_stimulus(output int num_cmds, output int wait_sum);
    int         fd;
    int         n;
    int         cycles;
    logic [7:0] cmd;
    num_cmds = 0;
    wait_sum = 0;
    fd = $fopen(stim_file, "r");
    if (fd != 0) begin
      while ($fscanf(fd, " %c", cmd) == 1) begin
        if (cmd == "D") begin
          n = $fscanf(fd, "%d", cycles);
          wait_sum = wait_sum + cycles;
        end
        if (cmd != "#") num_cmds = num_cmds + 1;
        skip_line(fd);
      end
      $fclose(fd);
    end
  endtask

  function automatic logic [2:0] port_code(input logic [127:0] name);
    if (name == 128'("boot_addr")) return 3'd0;
    if (name == 128'("pad_mux"))   return 3'd1;
    if (name == 128'("gpio_out"))  return 3'd2;
    if (name == 128'("gpio_dir"))  return 3'd3;
    if (name == 128'("irq"))       return 3'd4;
    return 3'd7;
  endfunction

  ////////////////////////////////////////
  // APB driver and checks
  ////////////////////////////////////////

  task automatic apb_write(input periph_pkg::apb_addr_t addr, input periph_pkg::apb_data_t data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk_int);
    #1;
    penable = 1'b1;
    @(posedge clk_int);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input periph_pkg::apb_addr_t addr, input periph_pkg::apb_data_t exp,
                          input logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk_int);
    #1;
    penable  = 1'b1;
    read_chk = 1'b1;
    exp_data = exp;
    exp_err  = err;
    @(posedge clk_int);
    #1;
    psel     = 1'b0;
    penable  = 1'b0;
    read_chk = 1'b0;
  endtask

  task automatic check_port(input logic [127:0] name, input periph_pkg::apb_data_t value);
    logic [2:0] code;
    code = port_code(name);
    if (code == 3'd7) begin
      $display("Stimulus file names an unknown port %0s", name);
      stim_errors = stim_errors + 1;
    end else begin
      port_sel = code;
      exp_data = value;
      port_chk = 1'b1;
      @(posedge clk_int);
      #1;
      port_chk = 1'b0;
    end
  endtask

  // Watchdog, armed once the stimulus length is known
  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_int);
      cycle_count = cycle_count + 1;
    end
    $display("The run timed out after %0d cycles without finishing", cycle_count);
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////
  // Main flow
  ////////////////////////////////////////

  initial begin : main_flow
    int                    fd;
    int                    n;
    int                    num_cmds;
    int                    wait_sum;
    int                    cycles;
    logic [7:0]            cmd;
    logic [127:0]          port_name;
    periph_pkg::apb_addr_t addr;
    periph_pkg::apb_data_t data;
    periph_pkg::gpio_vec_t pins;
    logic                  err;

    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    gpio_in      = '0;
    read_chk     = 1'b0;
    port_chk     = 1'b0;
    port_sel     = 3'd0;
    exp_data     = '0;
    exp_err      = 1'b0;
    stim_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;

    scan_stimulus(num_cmds, wait_sum);
    cycle_limit = 3 * num_cmds + wait_sum + 100;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", stim_file);
      $display("Some tests failed");
      $finish;
    end else begin
      repeat (2) @(posedge clk_int);
      #1;
      rst_n = 1'b1;
      while ($fscanf(fd, " %c", cmd) == 1) begin
        case (cmd)
          "#": skip_line(fd);
          "T": begin
            n = $fscanf(fd, "%d %s", test_num, test_name);
            errors_at_start = error_count + stim_errors;
          end
          "W": begin
            n = $fscanf(fd, "%h %h", addr, data);
            apb_write(addr, data);
          end
          "R": begin
            n = $fscanf(fd, "%h %h %h", addr, data, err);
            apb_read(addr, data, err);
          end
          "P": begin
            n = $fscanf(fd, "%h", pins);
            gpio_in = pins;
          end
          "D": begin
            n = $fscanf(fd, "%d", cycles);
            repeat (cycles) @(posedge clk_int);
            #1;
          end
          "C": begin
            n = $fscanf(fd, "%s %h", port_name, data);
            check_port(port_name, data);
          end
          "E": begin
            if (error_count + stim_errors == errors_at_start) begin
              $display("Test %0d %0s passed", test_num, test_name);
              tests_passed = tests_passed + 1;
            end else begin
              $display("Test %0d %0s failed with %0d errors", test_num, test_name,
                       error_count + stim_errors - errors_at_start);
              tests_failed = tests_failed + 1;
            end
          end
          default: begin
            $display("Stimulus file has an unknown command %c", cmd);
            stim_errors = stim_errors + 1;
            skip_line(fd);
          end
        endcase
      end
      $fclose(fd);
      $display("Tests passed: %0d, tests failed: %0d, errors: %0d", tests_passed, tests_failed,
               error_count + stim_errors);
      if (tests_failed == 0 && tests_passed > 0 && error_count + stim_errors == 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
      $finish;
    end
  end

endmodule

// ==== verification/periph_stim.txt ====
# T num name | W addr data | R addr data pslverr | P pins | D cycles | C port value | E
# Addresses and data in hex, test numbers and wait cycles in decimal
T 1 reset_values
C boot_addr 00008000
R 3000 00008000 0
R 3008 00000003 0
C pad_mux 00000000
C gpio_out 00000000
C gpio_dir 00000000
C irq 00000000
E
T 2 soc_ctrl_decode
W 3000 12345678
W 3004 0000a5a5
C boot_addr 12345678
C pad_mux 0000a5a5
R 3000 12345678 0
R 3004 0000a5a5 0
R 5000 00000000 1
E
T 3 gpio_data_path
W 0000 0000ffff
W 0004 00001234
C gpio_dir 0000ffff
C gpio_out 00001234
P 000000f0
D 4
R 0008 000000f0 0
P 00000000
D 4
E
T 4 timer_irq
W 2000 00000002
W 1008 00000014
W 1000 00000001
D 40
R 2004 00000002 0
C irq 00000002
W 1000 00000000
W 2004 00000002
R 2004 00000000 0
C irq 00000000
E
T 5 gpio_irq_mask
W 000c 00000008
P 00000008
D 6
R 2004 00000001 0
C irq 00000000
W 2000 00000001
R 2000 00000001 0
C irq 00000001
E
T 6 clock_gating
W 3008 00000002
W 0004 0000beef
C gpio_out 00001234
R 0004 00001234 0
W 3008 00000003
W 0004 0000beef
C gpio_out 0000beef
R 0004 0000beef 0
E

// ==== compile.f ====
+incdir+rtl
rtl/periph_pkg.sv
rtl/periph_apb_decoder.sv
rtl/periph_gpio.sv
rtl/periph_timer.sv
rtl/periph_event_unit.sv
rtl/periph_soc_ctrl.sv
rtl/periph_subsystem.sv
verification/periph_checker.sv
verification/periph_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds periph_tb with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module periph_tb -o periph_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/periph_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
  exit 0
fi
exit 1
